// ==== build.f ====
mem_map_pkg.sv
slot_ctrl_pkg.sv
s16_dwnld.sv
s16_ram_slots.sv
s16_rom_slots.sv
s16_bank_arbiter.sv
s16_sdram.sv
s16_sdram_properties.sv
tb_s16_sdram.sv

// ==== mem_map_pkg.sv ====
// SDRAM memory map of the board
// Word and address types, bank offsets, download region starts
package mem_map_pkg;

    typedef logic [21:0] sdram_addr_t;  // SDRAM word address
    typedef logic [31:0] sdram_data_t;  // Addressed word in the low half
    typedef logic [15:0] word_t;
    typedef logic [ 1:0] wmask_t;       // Byte enables, active low like dsn

    // CPU ROM starts at word 0
    localparam sdram_addr_t VRAM_OFFSET = 22'h10_0000;  // Work RAM and tilemap
    localparam sdram_addr_t GFX_OFFSET  = 22'h20_0000;  // Graphics ROM

    // Byte offset in the download stream
    localparam logic [24:0] BA1_START = 25'h100;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_s16_sdram \
    --Mdir obj_dir -o tb_s16_sdram
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_s16_sdram > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0

// ==== s16_bank_arbiter.sv ====
// Owner of the shared SDRAM port
// Round-robin between the banks, loader only while downloading
`timescale 1ns/1ps

module s16_bank_arbiter import mem_map_pkg::*, slot_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    // ROM loader, writes only
    input  logic        ld_req,
    input  sdram_addr_t ld_addr,
    input  word_t       ld_din,
    input  wmask_t      ld_mask,
    output logic        ld_ack,
    output logic        ld_rdy,
    input  logic        ba0_req,
    input  sdram_addr_t ba0_addr,
    input  logic        ba0_wr,
    input  word_t       ba0_din,
    input  wmask_t      ba0_mask,
    output logic        ba0_ack,
    output logic        ba0_rdy,
    // Bank 1 reads only
    input  logic        ba1_req,
    input  sdram_addr_t ba1_addr,
    output logic        ba1_ack,
    output logic        ba1_rdy,
    output sdram_addr_t sdram_addr,
    output logic        sdram_rd,
    output logic        sdram_wr,
    output word_t       sdram_din,
    output wmask_t      sdram_din_m,
    input  logic        sdram_ack,
    input  logic        sdram_rdy
);

arb_state_t st;
req_sel_t   owner, last_bank, grant;
logic       cmd_on;         // Command shown until ack
logic       grant_go;
logic       own_wr;

always_comb begin
    grant    = LOADER;
    grant_go = st == FREE || sdram_rdy;     // Hand over right at rdy
    if (ld_req) begin
        grant = LOADER;
    end else if (downloading) begin
        grant_go = 1'b0;
    end else if (ba0_req && (!ba1_req || last_bank == BANK1)) begin
        grant = BANK0;
    end else if (ba1_req) begin
        grant = BANK1;
    end else begin
        grant_go = 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        st        <= FREE;
        owner     <= LOADER;
        last_bank <= BANK1;     // So BANK0 goes first
        cmd_on    <= 1'b0;
    end else begin
        if (sdram_ack) cmd_on <= 1'b0;
        if (grant_go) begin
            st     <= BUSY;
            owner  <= grant;
            cmd_on <= 1'b1;
            if (grant != LOADER) last_bank <= grant;
        end else if (sdram_rdy) begin
            st <= FREE;
        end
    end
end

always_comb begin
    case (owner)
        BANK0: begin
            sdram_addr  = ba0_addr;
            sdram_din   = ba0_din;
            sdram_din_m = ba0_mask;
            own_wr      = ba0_wr;
        end
        BANK1: begin
            sdram_addr  = ba1_addr;
            sdram_din   = '0;
            sdram_din_m = 2'b11;
            own_wr      = 1'b0;
        end
        default: begin
            sdram_addr  = ld_addr;
            sdram_din   = ld_din;
            sdram_din_m = ld_mask;
            own_wr      = 1'b1;
        end
    endcase
end

assign sdram_rd = cmd_on && !own_wr;
assign sdram_wr = cmd_on && own_wr;

// Strobes go back to the owner only
assign ld_ack  = cmd_on && sdram_ack && owner == LOADER;
assign ba0_ack = cmd_on && sdram_ack && owner == BANK0;
assign ba1_ack = cmd_on && sdram_ack && owner == BANK1;
assign ld_rdy  = st == BUSY && sdram_rdy && owner == LOADER;
assign ba0_rdy = st == BUSY && sdram_rdy && owner == BANK0;
assign ba1_rdy = st == BUSY && sdram_rdy && owner == BANK1;

endmodule

// ==== s16_dwnld.sv ====
// ROM loader
// Packs download bytes into 16-bit SDRAM writes, one write per byte pair
`timescale 1ns/1ps

module s16_dwnld import mem_map_pkg::*, slot_ctrl_pkg::*; #(
    parameter bit SWAB = 1'b1
)(
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    output logic        req,
    output sdram_addr_t addr,
    output word_t       din,
    output wmask_t      mask,
    input  logic        ack,
    input  logic        rdy
);

slot_state_t st;
logic [ 7:0] even_byte;     // First byte of the pair
logic [24:0] gfx_rel;       // Offset inside the graphics part
logic        pair_done;

assign gfx_rel   = ioctl_addr - BA1_START;
assign pair_done = downloading && ioctl_wr && ioctl_addr[0];
assign req       = st == WAIT_ACK;
assign mask      = 2'b00;   // Always a full word

always_ff @(posedge clk) begin
    if (rst) begin
        st <= IDLE;
    end else begin
        case (st)
            IDLE:     if (pair_done) st <= WAIT_ACK;
            WAIT_ACK: if (ack) st <= WAIT_RDY;
            WAIT_RDY: if (rdy) st <= IDLE;
            default:  st <= IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (downloading && ioctl_wr && !ioctl_addr[0]) begin
        even_byte <= ioctl_data;
    end
    if (pair_done) begin
        // 68000 data is big endian
        din <= SWAB ? {even_byte, ioctl_data} : {ioctl_data, even_byte};
        if (ioctl_addr < BA1_START) begin
            addr <= sdram_addr_t'(ioctl_addr[24:1]);     // CPU ROM
        end else begin
            addr <= GFX_OFFSET + sdram_addr_t'(gfx_rel[24:1]);
        end
    end
end

endmodule

// ==== s16_ram_slots.sv ====
// Bank 0 slot controller
// CPU work RAM slot with masked writes, read-only tilemap slot
`timescale 1ns/1ps

module s16_ram_slots import mem_map_pkg::*, slot_ctrl_pkg::*; #(
    parameter int RAM_AW = 15,
    parameter int MAP_AW = 14
)(
    input  logic              clk,
    input  logic              rst,
    input  logic              ram_cs,
    input  logic [RAM_AW-1:0] main_addr,
    input  logic              main_rnw,
    input  word_t             main_dout,
    input  wmask_t            dsn,
    output word_t             ram_data,
    output logic              ram_ok,
    input  logic              map_cs,
    input  logic [MAP_AW-1:0] map_addr,
    output word_t             map_data,
    output logic              map_ok,
    output logic              req,
    output logic              wr,
    output sdram_addr_t       addr,
    output word_t             din,
    output wmask_t            mask,
    input  logic              ack,
    input  logic              rdy,
    input  sdram_data_t       data_read
);

slot_state_t st;
logic        sel_map;           // Tilemap owns the request
sdram_addr_t cpu_sd_addr, map_sd_addr;
sdram_addr_t cpu_addr_l, map_addr_l;
logic        cpu_wr_l;
word_t       cpu_din_l;
wmask_t      cpu_mask_l;
logic        cpu_valid, map_valid;
logic        cpu_hit, map_hit, cpu_same, map_same;
logic        cpu_rdy, map_rdy, map_stale;

assign cpu_sd_addr = VRAM_OFFSET + sdram_addr_t'(main_addr);
assign map_sd_addr = VRAM_OFFSET + sdram_addr_t'(map_addr);

// A read hits a cached read, a write only the same completed write
assign cpu_hit  = ram_cs && cpu_valid && cpu_addr_l == cpu_sd_addr &&
                  (main_rnw ? !cpu_wr_l : (cpu_wr_l && cpu_din_l == main_dout && cpu_mask_l == dsn));
assign cpu_same = ram_cs && addr == cpu_sd_addr &&
                  (main_rnw ? !wr : (wr && din == main_dout && mask == dsn));
assign map_hit  = map_cs && map_valid && map_addr_l == map_sd_addr;
assign map_same = map_cs && addr == map_sd_addr;

assign cpu_rdy   = rdy && !sel_map;
assign map_rdy   = rdy && sel_map;
assign map_stale = cpu_rdy && wr && addr == map_addr_l;    // CPU overwrote the tile word
assign req       = st == WAIT_ACK;

always_ff @(posedge clk) begin
    if (rst) begin
        st <= IDLE;
    end else begin
        case (st)
            IDLE:     if ((ram_cs && !cpu_hit) || (map_cs && !map_hit)) st <= WAIT_ACK;
            WAIT_ACK: if (ack) st <= WAIT_RDY;
            WAIT_RDY: if (rdy) st <= IDLE;
            default:  st <= IDLE;
        endcase
    end
end

// Request fields, frozen once the request leaves IDLE
always_ff @(posedge clk) begin
    if (st == IDLE) begin
        if (ram_cs && !cpu_hit) begin   // CPU first
            sel_map <= 1'b0;
            addr    <= cpu_sd_addr;
            wr      <= !main_rnw;
            din     <= main_dout;
            mask    <= dsn;
        end else begin
            sel_map <= 1'b1;
            addr    <= map_sd_addr;
            wr      <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (cpu_rdy) begin
        cpu_addr_l <= addr;
        cpu_wr_l   <= wr;
        cpu_din_l  <= din;
        cpu_mask_l <= mask;
        if (!wr) ram_data <= data_read[15:0];
    end
    if (map_rdy) begin
        map_addr_l <= addr;
        map_data   <= data_read[15:0];
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        cpu_valid <= 1'b0;
        map_valid <= 1'b0;
        ram_ok    <= 1'b0;
        map_ok    <= 1'b0;
    end else begin
        ram_ok <= cpu_rdy ? cpu_same : cpu_hit;
        map_ok <= map_rdy ? map_same : (map_hit && !map_stale);
        if (cpu_rdy) cpu_valid <= 1'b1;
        if (map_rdy) map_valid <= 1'b1;
        else if (map_stale) map_valid <= 1'b0;
    end
end

endmodule

// ==== s16_rom_slots.sv ====
// Bank 1 slot controller
// Two 32-bit graphics read slots, active while lvbl is high
`timescale 1ns/1ps

module s16_rom_slots import mem_map_pkg::*, slot_ctrl_pkg::*; #(
    parameter int SCR_AW = 17
)(
    input  logic              clk,
    input  logic              rst,
    input  logic              lvbl,
    input  logic [SCR_AW-1:0] scr1_addr,
    input  logic [SCR_AW-1:0] scr2_addr,
    output sdram_data_t       scr1_data,
    output sdram_data_t       scr2_data,
    output logic              scr1_ok,
    output logic              scr2_ok,
    output logic              req,
    output sdram_addr_t       addr,
    input  logic              ack,
    input  logic              rdy,
    input  sdram_data_t       data_read
);

slot_state_t st;
logic        sel;               // Index of the slot in flight
sdram_addr_t slot_addr [2];
sdram_addr_t addr_l    [2];     // Address of the cached data
sdram_data_t data_l    [2];
logic [1:0]  valid, hit, same, ok;

// Each slot address is a 32-bit unit, two SDRAM words
assign slot_addr[0] = GFX_OFFSET + sdram_addr_t'({scr1_addr, 1'b0});
assign slot_addr[1] = GFX_OFFSET + sdram_addr_t'({1'b1, scr2_addr, 1'b0}); // Upper half

assign scr1_data = data_l[0];
assign scr2_data = data_l[1];
assign scr1_ok   = ok[0];
assign scr2_ok   = ok[1];
assign req       = st == WAIT_ACK;

always_comb begin
    for (int i = 0; i < 2; i++) begin
        hit[i]  = lvbl && valid[i] && addr_l[i] == slot_addr[i];
        same[i] = lvbl && addr == slot_addr[i];
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        st <= IDLE;
    end else begin
        case (st)
            IDLE:     if (lvbl && !(&hit)) st <= WAIT_ACK;
            WAIT_ACK: if (ack) st <= WAIT_RDY;
            WAIT_RDY: if (rdy) st <= IDLE;
            default:  st <= IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (st == IDLE) begin
        sel  <= hit[0];     // scr1 first
        addr <= hit[0] ? slot_addr[1] : slot_addr[0];
    end
    if (rdy) begin
        addr_l[sel] <= addr;
        data_l[sel] <= data_read;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        valid <= '0;
        ok    <= '0;
    end else begin
        for (int i = 0; i < 2; i++) begin
            if (rdy && int'(sel) == i) begin
                valid[i] <= 1'b1;
                ok[i]    <= same[i];    // Address may have moved on
            end else begin
                ok[i] <= hit[i];
            end
        end
    end
end

endmodule

// ==== s16_sdram.sv ====
// Memory glue of the board: ROM loader, RAM and ROM banks
// Shared SDRAM port arbiter and the refresh enable
`timescale 1ns/1ps

module s16_sdram import mem_map_pkg::*; #(
    parameter int RAM_AW = 15,
    parameter int MAP_AW = 14,
    parameter int SCR_AW = 17,
    parameter bit SWAB   = 1'b1
)(
    input  logic              clk,
    input  logic              rst,
    input  logic              lvbl,
    input  logic              downloading,
    // Main CPU
    input  logic [RAM_AW-1:0] main_addr,
    input  word_t             main_dout,
    input  wmask_t            dsn,
    input  logic              main_rnw,
    input  logic              ram_cs,
    output word_t             ram_data,
    output logic              ram_ok,
    // Tilemap
    input  logic [MAP_AW-1:0] map_addr,
    output word_t             map_data,
    output logic              map_ok,
    // Scroll graphics
    input  logic [SCR_AW-1:0] scr1_addr,
    input  logic [SCR_AW-1:0] scr2_addr,
    output sdram_data_t       scr1_data,
    output logic              scr1_ok,
    output sdram_data_t       scr2_data,
    output logic              scr2_ok,
    input  logic [24:0]       ioctl_addr,
    input  logic [ 7:0]       ioctl_data,
    input  logic              ioctl_wr,
    // SDRAM port
    output sdram_addr_t       sdram_addr,
    output logic              sdram_rd,
    output logic              sdram_wr,
    output word_t             sdram_din,
    output wmask_t            sdram_din_m,
    input  logic              sdram_ack,
    input  logic              sdram_rdy,
    input  sdram_data_t       data_read,
    output logic              refresh_en
);

logic        ld_req, ld_ack, ld_rdy;
sdram_addr_t ld_addr;
word_t       ld_din;
wmask_t      ld_mask;
logic        ba0_req, ba0_wr, ba0_ack, ba0_rdy;
sdram_addr_t ba0_addr;
word_t       ba0_din;
wmask_t      ba0_mask;
logic        ba1_req, ba1_ack, ba1_rdy;
sdram_addr_t ba1_addr;

// Refresh enable is lvbl one clock later
always_ff @(posedge clk) begin
    if (rst) refresh_en <= 1'b0;
    else refresh_en <= lvbl;
end

s16_dwnld #(.SWAB(SWAB)) u_dwnld (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .downloading ( downloading ),
    .ioctl_addr  ( ioctl_addr  ),
    .ioctl_data  ( ioctl_data  ),
    .ioctl_wr    ( ioctl_wr    ),
    .req         ( ld_req      ),
    .addr        ( ld_addr     ),
    .din         ( ld_din      ),
    .mask        ( ld_mask     ),
    .ack         ( ld_ack      ),
    .rdy         ( ld_rdy      )
);

s16_ram_slots #(.RAM_AW(RAM_AW), .MAP_AW(MAP_AW)) u_bank0 (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .ram_cs    ( ram_cs    ),
    .main_addr ( main_addr ),
    .main_rnw  ( main_rnw  ),
    .main_dout ( main_dout ),
    .dsn       ( dsn       ),
    .ram_data  ( ram_data  ),
    .ram_ok    ( ram_ok    ),
    .map_cs    ( lvbl      ),   // Tilemap fetches in active video
    .map_addr  ( map_addr  ),
    .map_data  ( map_data  ),
    .map_ok    ( map_ok    ),
    .req       ( ba0_req   ),
    .wr        ( ba0_wr    ),
    .addr      ( ba0_addr  ),
    .din       ( ba0_din   ),
    .mask      ( ba0_mask  ),
    .ack       ( ba0_ack   ),
    .rdy       ( ba0_rdy   ),
    .data_read ( data_read )
);

s16_rom_slots #(.SCR_AW(SCR_AW)) u_bank1 (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .lvbl      ( lvbl      ),
    .scr1_addr ( scr1_addr ),
    .scr2_addr ( scr2_addr ),
    .scr1_data ( scr1_data ),
    .scr2_data ( scr2_data ),
    .scr1_ok   ( scr1_ok   ),
    .scr2_ok   ( scr2_ok   ),
    .req       ( ba1_req   ),
    .addr      ( ba1_addr  ),
    .ack       ( ba1_ack   ),
    .rdy       ( ba1_rdy   ),
    .data_read ( data_read )
);

s16_bank_arbiter u_arbiter (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .downloading ( downloading ),
    .ld_req      ( ld_req      ),
    .ld_addr     ( ld_addr     ),
    .ld_din      ( ld_din      ),
    .ld_mask     ( ld_mask     ),
    .ld_ack      ( ld_ack      ),
    .ld_rdy      ( ld_rdy      ),
    .ba0_req     ( ba0_req     ),
    .ba0_addr    ( ba0_addr    ),
    .ba0_wr      ( ba0_wr      ),
    .ba0_din     ( ba0_din     ),
    .ba0_mask    ( ba0_mask    ),
    .ba0_ack     ( ba0_ack     ),
    .ba0_rdy     ( ba0_rdy     ),
    .ba1_req     ( ba1_req     ),
    .ba1_addr    ( ba1_addr    ),
    .ba1_ack     ( ba1_ack     ),
    .ba1_rdy     ( ba1_rdy     ),
    .sdram_addr  ( sdram_addr  ),
    .sdram_rd    ( sdram_rd    ),
    .sdram_wr    ( sdram_wr    ),
    .sdram_din   ( sdram_din   ),
    .sdram_din_m ( sdram_din_m ),
    .sdram_ack   ( sdram_ack   ),
    .sdram_rdy   ( sdram_rdy   )
);

endmodule

// ==== s16_sdram_properties.sv ====
// Concurrent assertions on the shared SDRAM port
// Command exclusivity, command hold until ack, download lock
`timescale 1ns/1ps

module s16_sdram_properties import mem_map_pkg::*, slot_ctrl_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        downloading,
    input logic        sdram_rd,
    input logic        sdram_wr,
    input logic        sdram_ack,
    input sdram_addr_t sdram_addr,
    input word_t       sdram_din,
    input wmask_t      sdram_din_m,
    input sdram_addr_t ld_addr,
    input req_sel_t    owner
);

a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(sdram_rd && sdram_wr))
    else $error("SDRAM read and write high together");

// Command and fields frozen until the model accepts it
a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
    (sdram_rd || sdram_wr) && !sdram_ack |=>
        $stable(sdram_rd) && $stable(sdram_wr) && $stable(sdram_addr) &&
        $stable(sdram_din) && $stable(sdram_din_m))
    else $error("SDRAM command changed before ack");

a_ack_cmd: assert property (@(posedge clk) disable iff (rst)
    sdram_ack |-> sdram_rd || sdram_wr)
    else $error("SDRAM ack without a command");

// Only loader writes reach the port while downloading
a_dl_lock: assert property (@(posedge clk) disable iff (rst)
    downloading && (sdram_rd || sdram_wr) |->
        owner == LOADER && sdram_wr && sdram_addr == ld_addr)
    else $error("Bank command on the port while downloading");

endmodule

bind s16_bank_arbiter s16_sdram_properties u_properties (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .downloading ( downloading ),
    .sdram_rd    ( sdram_rd    ),
    .sdram_wr    ( sdram_wr    ),
    .sdram_ack   ( sdram_ack   ),
    .sdram_addr  ( sdram_addr  ),
    .sdram_din   ( sdram_din   ),
    .sdram_din_m ( sdram_din_m ),
    .ld_addr     ( ld_addr     ),
    .owner       ( owner       )
);

// ==== slot_ctrl_pkg.sv ====
// State encodings for the slot controllers, loader and arbiter
// Requester codes for the shared SDRAM port
package slot_ctrl_pkg;

    // Slot controllers and the ROM loader
    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_RDY
    } slot_state_t;

    typedef enum logic {
        FREE,
        BUSY
    } arb_state_t;

    typedef enum logic [1:0] {
        LOADER,
        BANK0,
        BANK1
    } req_sel_t;

endpackage

// ==== tb_s16_sdram.sv ====
// Testbench for the SDRAM glue: clock, SDRAM model, stimulus
// Reference model of the memory contents and the ok edge checker
`timescale 1ns/1ps

module tb_s16_sdram import mem_map_pkg::*, slot_ctrl_pkg::*;;

localparam int CMD_MAX    = 11;                 // Grant, ack wait, rdy wait
localparam int LAT_MAX    = 4 * CMD_MAX + 4;    // Three other commands plus its own
localparam int MAX_CYCLES = 40000;              // Download near 9000, phases under 20000

logic        clk, rst, lvbl, downloading;
logic [14:0] main_addr;
word_t       main_dout, ram_data, map_data;
wmask_t      dsn, sdram_din_m;
logic        main_rnw, ram_cs, ram_ok, map_ok, scr1_ok, scr2_ok;
logic [13:0] map_addr;
logic [16:0] scr1_addr, scr2_addr;
sdram_data_t scr1_data, scr2_data, data_read;
logic [24:0] ioctl_addr;
logic [ 7:0] ioctl_data;
logic        ioctl_wr, sdram_rd, sdram_wr, sdram_ack, sdram_rdy, refresh_en;
sdram_addr_t sdram_addr;
word_t       sdram_din;

logic [7:0]  img [512];                 // Download image
word_t       shadow [sdram_addr_t];     // Every RAM write, merged by mask
word_t       mem [sdram_addr_t];        // SDRAM model contents
int          errors, checks, cycles;
logic        ram_ok_q, map_ok_q, scr1_ok_q, scr2_ok_q;

s16_sdram #(.RAM_AW(15), .MAP_AW(14), .SCR_AW(17), .SWAB(1'b1)) i_s16_sdram (.*);

always #2 clk = ~clk;

// Unwritten words read as a pattern of the whole address
function automatic word_t fill_word(input sdram_addr_t a);
    return a[15:0] ^ {a[21:16], a[21:12]} ^ 16'h5a3c;
endfunction

function automatic word_t mem_rd(input sdram_addr_t a);
    return mem.exists(a) ? mem[a] : fill_word(a);
endfunction

// Expected word at an SDRAM address
function automatic word_t ref_word(input sdram_addr_t a);
    int b;
    if (shadow.exists(a)) return shadow[a];
    if (a < 22'h80) begin
        b = 2 * int'(a);
    end else if (a >= GFX_OFFSET && a < GFX_OFFSET + 22'h80) begin
        b = 256 + 2 * int'(a - GFX_OFFSET);
    end else begin
        return fill_word(a);
    end
    return {img[b], img[b + 1]};    // Big endian pairs
endfunction

function automatic logic ok_of(input int slot);
    case (slot)
        0:       return ram_ok;
        1:       return map_ok;
        2:       return scr1_ok;
        default: return scr2_ok;
    endcase
endfunction

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
endtask

// Called right after driving on a clock edge
task automatic wait_ok(input int slot, output int lat);
    @(posedge clk);
    @(posedge clk);
    lat = 2;
    while (!ok_of(slot)) begin
        @(posedge clk);
        lat++;
    end
endtask

task automatic cpu_write(input logic [14:0] a, input word_t d, input wmask_t m);
    word_t w;
    int lat;
    @(posedge clk);
    ram_cs    <= 1'b1;
    main_rnw  <= 1'b0;
    main_addr <= a;
    main_dout <= d;
    dsn       <= m;
    wait_ok(0, lat);
    w = ref_word(VRAM_OFFSET + sdram_addr_t'(a));
    if (!m[1]) w[15:8] = d[15:8];
    if (!m[0]) w[7:0] = d[7:0];
    shadow[VRAM_OFFSET + sdram_addr_t'(a)] = w;
endtask

task automatic cpu_read(input logic [14:0] a);
    int lat;
    @(posedge clk);
    ram_cs    <= 1'b1;
    main_rnw  <= 1'b1;
    main_addr <= a;
    wait_ok(0, lat);
endtask

// One command at a time, random ack and rdy delays
always begin : sdram_model
    sdram_addr_t a;
    logic        w;
    word_t       d, old;
    wmask_t      m;
    @(posedge clk);
    if (!rst && (sdram_rd || sdram_wr)) begin
        a = sdram_addr;
        w = sdram_wr;
        d = sdram_din;
        m = sdram_din_m;
        repeat ($urandom % 4) @(posedge clk);
        sdram_ack <= 1'b1;
        @(posedge clk);
        sdram_ack <= 1'b0;
        repeat (1 + $urandom % 4) @(posedge clk);
        if (w) begin
            old = mem_rd(a);
            if (!m[1]) old[15:8] = d[15:8];
            if (!m[0]) old[7:0] = d[7:0];
            mem[a] = old;
        end else begin
            data_read <= {mem_rd(a + 22'd1), mem_rd(a)};
        end
        sdram_rdy <= 1'b1;
        @(posedge clk);
        sdram_rdy <= 1'b0;
    end
end

// Each ok rising edge against the reference
always @(posedge clk) begin : compare
    sdram_addr_t g;
    if (!rst) begin
        if (ram_ok && !ram_ok_q && ram_cs && main_rnw)
            check_val("ram_data", {16'h0, ram_data},
                      {16'h0, ref_word(VRAM_OFFSET + sdram_addr_t'(main_addr))});
        if (map_ok && !map_ok_q)
            check_val("map_data", {16'h0, map_data},
                      {16'h0, ref_word(VRAM_OFFSET + sdram_addr_t'(map_addr))});
        if (scr1_ok && !scr1_ok_q) begin
            g = GFX_OFFSET + sdram_addr_t'({scr1_addr, 1'b0});
            check_val("scr1_data", scr1_data, {ref_word(g + 22'd1), ref_word(g)});
        end
        if (scr2_ok && !scr2_ok_q) begin
            g = GFX_OFFSET + sdram_addr_t'({1'b1, scr2_addr, 1'b0});
            check_val("scr2_data", scr2_data, {ref_word(g + 22'd1), ref_word(g)});
        end
    end
    ram_ok_q  <= ram_ok;
    map_ok_q  <= map_ok;
    scr1_ok_q <= scr1_ok;
    scr2_ok_q <= scr2_ok;
end

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end
end

initial begin
    int lat [4];
    logic [14:0] wa;
    void'($urandom(32'h0be1_5460));
    clk         = 1'b0;
    rst         = 1'b1;
    lvbl        = 1'b0;
    downloading = 1'b0;
    main_addr   = '0;
    main_dout   = '0;
    dsn         = 2'b11;
    main_rnw    = 1'b1;
    ram_cs      = 1'b0;
    map_addr    = '0;
    scr1_addr   = '0;
    scr2_addr   = '0;
    ioctl_addr  = '0;
    ioctl_data  = '0;
    ioctl_wr    = 1'b0;
    sdram_ack   = 1'b0;
    sdram_rdy   = 1'b0;
    data_read   = '0;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    ram_ok_q    = 1'b0;
    map_ok_q    = 1'b0;
    scr1_ok_q   = 1'b0;
    scr2_ok_q   = 1'b0;
    for (int i = 0; i < 512; i++) img[i] = 8'($urandom);
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Quiet after reset
    for (int i = 0; i < 4; i++) begin
        @(posedge clk);
        check_val("ok flags", {ram_ok, map_ok, scr1_ok, scr2_ok}, 0);
        check_val("sdram_rd/wr", {sdram_rd, sdram_wr}, 0);
        check_val("req", {i_s16_sdram.ld_req, i_s16_sdram.ba0_req, i_s16_sdram.ba1_req}, 0);
    end
    @(posedge clk);
    downloading <= 1'b1;
    lvbl        <= 1'b1;
    @(posedge clk);
    check_val("refresh_en", refresh_en, 0);     // One register behind lvbl
    @(posedge clk);
    check_val("refresh_en", refresh_en, 1);
    lvbl <= 1'b0;
    @(posedge clk);
    check_val("refresh_en", refresh_en, 1);
    @(posedge clk);
    check_val("refresh_en", refresh_en, 0);

    // Download, spaced so the loader never overruns
    for (int i = 0; i < 512; i++) begin
        @(posedge clk);
        ioctl_addr <= 25'(i);
        ioctl_data <= img[i];
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr <= 1'b0;
        repeat (15) @(posedge clk);
    end
    while (i_s16_sdram.u_dwnld.st != IDLE || i_s16_sdram.u_arbiter.st != FREE)
        @(posedge clk);

    // Loader words in both ROM regions
    for (int w = 0; w < 128; w++) begin
        check_val("sdram_din cpu rom", {16'h0, mem_rd(sdram_addr_t'(w))},
                  {16'h0, ref_word(sdram_addr_t'(w))});
        check_val("sdram_din gfx rom", {16'h0, mem_rd(GFX_OFFSET + sdram_addr_t'(w))},
                  {16'h0, ref_word(GFX_OFFSET + sdram_addr_t'(w))});
    end
    downloading <= 1'b0;

    // Graphics reads
    @(posedge clk);
    lvbl <= 1'b1;
    for (int n = 0; n < 16; n++) begin
        @(posedge clk);
        scr1_addr <= 17'($urandom % 64);
        scr2_addr <= 17'($urandom);
        fork
            wait_ok(2, lat[2]);
            wait_ok(3, lat[3]);
        join
    end

    // Masked CPU writes, each dsn value
    for (int m = 0; m < 4; m++) begin
        wa = 15'($urandom);
        cpu_write(wa, word_t'($urandom), wmask_t'(m));
        cpu_read(wa);
    end

    // All four slots at once
    for (int n = 0; n < 8; n++) begin
        @(posedge clk);
        main_rnw  <= 1'b1;
        main_addr <= 15'($urandom);
        map_addr  <= 14'($urandom);
        scr1_addr <= 17'($urandom);
        scr2_addr <= 17'($urandom);
        fork
            wait_ok(0, lat[0]);
            wait_ok(1, lat[1]);
            wait_ok(2, lat[2]);
            wait_ok(3, lat[3]);
        join
        for (int s = 0; s < 4; s++) begin
            assert (lat[s] <= LAT_MAX) else begin
                errors++;
                $display("Slot %0d waited %0d cycles for ok, limit %0d", s, lat[s], LAT_MAX);
            end
        end
    end

    // New address drops ok
    @(posedge clk);
    scr1_addr <= scr1_addr + 17'd1;
    @(posedge clk);
    @(posedge clk);
    check_val("scr1_ok", scr1_ok, 0);
    while (!scr1_ok) @(posedge clk);

    // Blanking holds bank 1 off
    @(posedge clk);
    lvbl      <= 1'b0;
    scr1_addr <= scr1_addr + 17'd1;
    scr2_addr <= scr2_addr + 17'd1;
    repeat (2) @(posedge clk);
    for (int i = 0; i < 30; i++) begin
        @(posedge clk);
        check_val("scr1_ok/scr2_ok", {scr1_ok, scr2_ok}, 0);
        check_val("ba1_req", i_s16_sdram.ba1_req, 0);
    end

    repeat (5) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("TEST RESULT: PASS");
    end else begin
        $display("TEST RESULT: FAIL");
    end
    $finish;
end

endmodule
